// ==== rtl/bp_params.svh ====
`ifndef BP_PARAMS_SVH
`define BP_PARAMS_SVH

// table geometry, history must be as wide as the index for the xor hash
`define BP_INDEX_BITS 5 // 32 btb and counter entries
`define BP_HIST_BITS  5

// saturating counter width, msb is the taken prediction
`define BP_CTR_BITS   2

// first fetch address as a byte address
`define BP_RESET_PC   32'h4000_0000

`endif

// ==== rtl/bp_types_pkg.sv ====
`default_nettype none

`include "bp_params.svh"

package bp_types_pkg;

    // halfword address, byte address bits 31:1
    typedef logic [30:0] pc_t;

    typedef logic [`BP_INDEX_BITS-1:0] bp_index_t;
    typedef logic [`BP_HIST_BITS-1:0]  ghr_t;
    typedef logic [`BP_CTR_BITS-1:0]   counter_t; // saturating

    // what the execute stage has to repair
    typedef enum logic [1:0] {
        FIX_NONE      = 2'd0,
        FIX_NOT_TAKEN = 2'd1, // predicted taken, fell through
        FIX_TAKEN     = 2'd2, // predicted not taken, jumped
        FIX_TARGET    = 2'd3  // both taken, wrong target
    } fix_kind_e;

endpackage

`default_nettype wire

// ==== rtl/pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;
    import bp_types_pkg::*;

    // fetch -> decode
    typedef struct packed {
        logic        valid;
        pc_t         pc;
        logic [31:0] instr;
        logic        pred_taken;
        pc_t         pred_target;
        ghr_t        ghr_snap; // history seen by the lookup
    } fetch_pkt_t;

    // decode -> execute, instruction word already classified
    typedef struct packed {
        logic valid;
        pc_t  pc;
        logic pred_taken;
        pc_t  pred_target;
        ghr_t ghr_snap;
        logic is_ctrl;
        logic is_cond;
        logic is_compressed;
    } decode_pkt_t;

    // execute -> predictor
    typedef struct packed {
        logic valid;
        logic is_cond;
        logic taken;     // resolved outcome
        logic btb_write; // taken and mispredicted
        pc_t  pc;
        pc_t  target;
        ghr_t ghr_snap;
    } train_t;

    // execute -> fetch and flush
    typedef struct packed {
        logic      valid;
        pc_t       pc;
        fix_kind_e kind;
    } redirect_t;

endpackage

`default_nettype wire

// ==== rtl/pc_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bp_params.svh"

module pc_gen (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                stall_i,
    input  pipe_pkg::redirect_t redirect_i,
    input  logic                pred_taken_i,
    input  bp_types_pkg::pc_t   pred_target_i,
    input  logic                instr_compressed_i,
    output bp_types_pkg::pc_t   pc_o
);
    import bp_types_pkg::*;

    localparam pc_t RESET_PC = pc_t'(`BP_RESET_PC >> 1);

    pc_t pc_q;
    pc_t pc_seq;
    pc_t pc_next;

    // one halfword for rvc, two otherwise
    assign pc_seq = pc_q + (instr_compressed_i ? pc_t'(1) : pc_t'(2));

    always_comb begin
        if (redirect_i.valid) begin
            pc_next = redirect_i.pc; // execute wins over the prediction
        end else if (pred_taken_i) begin
            pc_next = pred_target_i;
        end else begin
            pc_next = pc_seq;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc_q <= RESET_PC;
        end else if (!stall_i) begin
            pc_q <= pc_next;
        end
    end

    assign pc_o = pc_q;

    // execute must hold its redirect back while the pipe is frozen
    redirect_not_in_stall_a: assert property (
        @(posedge clk_i) disable iff (rst_i)
        stall_i |-> !redirect_i.valid
    );

endmodule

`default_nettype wire

// ==== rtl/gshare_predictor.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bp_params.svh"

module gshare_predictor (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  bp_types_pkg::pc_t     lookup_pc_i,
    output logic                  pred_taken_o,
    output bp_types_pkg::pc_t     pred_target_o,
    output bp_types_pkg::ghr_t    ghr_o,
    input  pipe_pkg::train_t      train_i
);
    import bp_types_pkg::*;

    localparam int       ENTRIES  = 1 << `BP_INDEX_BITS;
    localparam pc_t      RESET_PC = pc_t'(`BP_RESET_PC >> 1);
    localparam counter_t CTR_MAX  = '1;

    pc_t      btb_q [ENTRIES];
    counter_t ctr_q [ENTRIES];
    ghr_t     ghr_q;

    bp_index_t lookup_idx;  // btb slot, byte pc bits 5:1
    bp_index_t lookup_cidx; // hashed with live history
    bp_index_t train_idx;
    bp_index_t train_cidx;  // hashed with the snapshot from fetch
    counter_t  train_ctr;

    assign lookup_idx  = lookup_pc_i[`BP_INDEX_BITS-1:0];
    assign lookup_cidx = lookup_idx ^ ghr_q;
    assign train_idx   = train_i.pc[`BP_INDEX_BITS-1:0];
    assign train_cidx  = train_idx ^ train_i.ghr_snap;
    assign train_ctr   = ctr_q[train_cidx];

    assign pred_target_o = btb_q[lookup_idx];
    assign pred_taken_o  = ctr_q[lookup_cidx][`BP_CTR_BITS-1];
    assign ghr_o         = ghr_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < ENTRIES; i++) begin
                btb_q[i] <= RESET_PC;
                ctr_q[i] <= '0; // strongly not taken
            end
            ghr_q <= '0;
        end else if (train_i.valid) begin
            if (train_i.btb_write) begin
                btb_q[train_idx] <= train_i.target;
            end
            if (train_i.is_cond) begin
                if (train_i.taken) begin
                    if (train_ctr != CTR_MAX) begin
                        ctr_q[train_cidx] <= train_ctr + 1'b1;
                    end
                end else if (train_ctr != '0) begin
                    ctr_q[train_cidx] <= train_ctr - 1'b1;
                end
                // resolved history only, no speculative update
                ghr_q <= {ghr_q[`BP_HIST_BITS-2:0], train_i.taken};
            end
        end
    end

    // execute register is cleared by the first reset edge
    no_train_in_reset_a: assert property (
        @(posedge clk_i)
        rst_i && $past(rst_i) |-> !train_i.valid
    );

    // a taken update never wraps to zero
    ctr_no_wrap_up_a: assert property (
        @(posedge clk_i) disable iff (rst_i)
        train_i.valid && train_i.is_cond && train_i.taken
            |=> ctr_q[$past(train_cidx)] != '0
    );

    // and a not-taken update never wraps to max
    ctr_no_wrap_down_a: assert property (
        @(posedge clk_i) disable iff (rst_i)
        train_i.valid && train_i.is_cond && !train_i.taken
            |=> ctr_q[$past(train_cidx)] != CTR_MAX
    );

endmodule

`default_nettype wire

// ==== rtl/branch_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_decode (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  stall_i,
    input  logic                  flush_i,
    input  pipe_pkg::fetch_pkt_t  fetch_i,
    output pipe_pkg::decode_pkt_t decode_o
);
    import pipe_pkg::*;

    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    fetch_pkt_t fd_q;

    logic [31:0] instr;
    logic [2:0]  c_funct3;
    logic        is_compressed;
    logic        c_quad1;
    logic        c_jump;   // c.j, c.jal
    logic        c_branch; // c.beqz, c.bnez
    logic        op_jump;
    logic        op_branch;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            fd_q.valid <= 1'b0;
        end else if (!stall_i) begin
            fd_q <= fetch_i;
            if (flush_i) begin
                fd_q.valid <= 1'b0; // wrong path
            end
        end
    end

    assign instr         = fd_q.instr;
    assign c_funct3      = instr[15:13];
    assign is_compressed = instr[1:0] != 2'b11;

    assign c_quad1  = instr[1:0] == 2'b01;
    assign c_jump   = c_quad1 && (c_funct3 == 3'b001 || c_funct3 == 3'b101);
    assign c_branch = c_quad1 && c_funct3[2:1] == 2'b11;

    assign op_jump   = instr[6:0] == OP_JAL || instr[6:0] == OP_JALR;
    assign op_branch = instr[6:0] == OP_BRANCH;

    always_comb begin
        decode_o.valid         = fd_q.valid;
        decode_o.pc            = fd_q.pc;
        decode_o.pred_taken    = fd_q.pred_taken;
        decode_o.pred_target   = fd_q.pred_target;
        decode_o.ghr_snap      = fd_q.ghr_snap;
        decode_o.is_compressed = is_compressed;
        if (is_compressed) begin
            decode_o.is_ctrl = c_jump || c_branch;
            decode_o.is_cond = c_branch;
        end else begin
            decode_o.is_ctrl = op_jump || op_branch;
            decode_o.is_cond = op_branch;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/branch_check.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_check (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  stall_i,
    input  pipe_pkg::decode_pkt_t decode_i,
    input  logic                  exec_taken_i,
    input  bp_types_pkg::pc_t     exec_target_i,
    output bp_types_pkg::pc_t     exec_pc_o,
    output logic                  exec_valid_o,
    output pipe_pkg::redirect_t   redirect_o,
    output pipe_pkg::train_t      train_o
);
    import bp_types_pkg::*;
    import pipe_pkg::*;

    decode_pkt_t ex_q;

    logic      active;     // real instruction and pipe moving
    logic      pred_taken;
    logic      act_taken;
    pc_t       pc_seq;
    fix_kind_e fix;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ex_q.valid <= 1'b0;
        end else if (!stall_i) begin
            ex_q <= decode_i;
            if (redirect_o.valid) begin
                ex_q.valid <= 1'b0;
            end
        end
    end

    assign active     = ex_q.valid && !stall_i;
    assign pred_taken = active && ex_q.pred_taken;
    assign act_taken  = active && ex_q.is_ctrl && exec_taken_i;
    assign pc_seq     = ex_q.pc + (ex_q.is_compressed ? pc_t'(1) : pc_t'(2));

    always_comb begin
        if (pred_taken && !act_taken) begin
            fix = FIX_NOT_TAKEN;
        end else if (!pred_taken && act_taken) begin
            fix = FIX_TAKEN;
        end else if (act_taken && ex_q.pred_target != exec_target_i) begin
            fix = FIX_TARGET;
        end else begin
            fix = FIX_NONE;
        end
    end

    assign redirect_o.valid = fix != FIX_NONE;
    assign redirect_o.kind  = fix;
    assign redirect_o.pc    = (fix == FIX_NOT_TAKEN) ? pc_seq : exec_target_i;

    assign train_o.valid     = active;
    assign train_o.is_cond   = ex_q.is_cond;
    assign train_o.taken     = act_taken;
    assign train_o.btb_write = act_taken && fix != FIX_NONE;
    assign train_o.pc        = ex_q.pc;
    assign train_o.target    = exec_target_i;
    assign train_o.ghr_snap  = ex_q.ghr_snap;

    assign exec_pc_o    = ex_q.pc;
    assign exec_valid_o = ex_q.valid;

    // the decode slot behind a redirect is wrong path and must arrive squashed
    redirect_flush_a: assert property (
        @(posedge clk_i) disable iff (rst_i)
        redirect_o.valid |=> !decode_i.valid
    );

endmodule

`default_nettype wire

// ==== rtl/branch_front_end.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_front_end (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    stall_i,
    input  logic [31:0]             instr_i,
    output bp_types_pkg::pc_t       fetch_pc_o,
    output bp_types_pkg::pc_t       exec_pc_o,
    output logic                    exec_valid_o,
    input  logic                    exec_taken_i,
    input  bp_types_pkg::pc_t       exec_target_i,
    output logic                    redirect_valid_o,
    output bp_types_pkg::fix_kind_e redirect_kind_o
);
    import bp_types_pkg::*;
    import pipe_pkg::*;

    pc_t         fetch_pc;
    logic        pred_taken;
    pc_t         pred_target;
    ghr_t        ghr;
    fetch_pkt_t  fetch_pkt;
    decode_pkt_t decode_pkt;
    redirect_t   redirect;
    train_t      train;

    // every fetch is real, wrong path is squashed downstream
    assign fetch_pkt.valid       = 1'b1;
    assign fetch_pkt.pc          = fetch_pc;
    assign fetch_pkt.instr       = instr_i;
    assign fetch_pkt.pred_taken  = pred_taken;
    assign fetch_pkt.pred_target = pred_target;
    assign fetch_pkt.ghr_snap    = ghr;

    pc_gen pc_gen_inst (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .stall_i            (stall_i),
        .redirect_i         (redirect),
        .pred_taken_i       (pred_taken),
        .pred_target_i      (pred_target),
        .instr_compressed_i (instr_i[1:0] != 2'b11),
        .pc_o               (fetch_pc)
    );

    gshare_predictor gshare_predictor_inst (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .lookup_pc_i   (fetch_pc),
        .pred_taken_o  (pred_taken),
        .pred_target_o (pred_target),
        .ghr_o         (ghr),
        .train_i       (train)
    );

    branch_decode branch_decode_inst (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .stall_i  (stall_i),
        .flush_i  (redirect.valid),
        .fetch_i  (fetch_pkt),
        .decode_o (decode_pkt)
    );

    branch_check branch_check_inst (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .stall_i       (stall_i),
        .decode_i      (decode_pkt),
        .exec_taken_i  (exec_taken_i),
        .exec_target_i (exec_target_i),
        .exec_pc_o     (exec_pc_o),
        .exec_valid_o  (exec_valid_o),
        .redirect_o    (redirect),
        .train_o       (train)
    );

    assign fetch_pc_o       = fetch_pc;
    assign redirect_valid_o = redirect.valid;
    assign redirect_kind_o  = redirect.kind;

endmodule

`default_nettype wire

// ==== verification/tb_branch_front_end.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bp_params.svh"

module tb_branch_front_end;
    import bp_types_pkg::*;

    localparam int         N_CYCLES    = 2000;
    localparam int         WATCHDOG_NS = N_CYCLES * 20;
    localparam int         ENTRIES     = 1 << `BP_INDEX_BITS;
    localparam pc_t        BASE_PC     = pc_t'(`BP_RESET_PC >> 1);
    localparam logic [1:0] CLS_PLAIN   = 2'd0;
    localparam logic [1:0] CLS_RVC     = 2'd1;
    localparam logic [1:0] CLS_JAL     = 2'd2;
    localparam logic [1:0] CLS_BRANCH  = 2'd3;

    // one pipeline slot as the model sees it
    typedef struct packed {
        logic valid;
        pc_t  pc;
        logic pred_taken;
        pc_t  pred_target;
        ghr_t ghr_snap;
    } stage_t;

    logic        clk_i;
    logic        rst_i;
    logic        stall_i;
    logic [31:0] instr_i;
    pc_t         fetch_pc_o;
    pc_t         exec_pc_o;
    logic        exec_valid_o;
    logic        exec_taken_i;
    pc_t         exec_target_i;
    logic        redirect_valid_o;
    fix_kind_e   redirect_kind_o;

    logic [31:0] lfsr_q;
    logic [1:0]  cls_q  [64]; // one program slot per halfword
    logic [5:0]  tgt_q  [64];
    logic [7:0]  bias_q [64]; // branch outcome pattern
    int          iter_q [64];

    pc_t         btb_m  [ENTRIES];
    counter_t    ctr_m  [ENTRIES];
    ghr_t        ghr_m;
    pc_t         fpc_m;
    stage_t      fd_m;
    stage_t      ex_m;
    int          resolved;
    int          hits;

    branch_front_end branch_front_end_inst (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .stall_i          (stall_i),
        .instr_i          (instr_i),
        .fetch_pc_o       (fetch_pc_o),
        .exec_pc_o        (exec_pc_o),
        .exec_valid_o     (exec_valid_o),
        .exec_taken_i     (exec_taken_i),
        .exec_target_i    (exec_target_i),
        .redirect_valid_o (redirect_valid_o),
        .redirect_kind_o  (redirect_kind_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] instr_of(input logic [1:0] cls);
        case (cls)
            CLS_PLAIN: return 32'h0000_0013; // addi x0, x0, 0
            CLS_RVC:   return 32'h0000_0001; // c.nop
            CLS_JAL:   return 32'h0000_006f;
            default:   return 32'h0000_0063; // beq
        endcase
    endfunction

    function automatic pc_t len_of(input logic [1:0] cls);
        return (cls == CLS_RVC) ? pc_t'(1) : pc_t'(2);
    endfunction

    // correction kind for the instruction in execute
    function automatic fix_kind_e fix_of(input stage_t ex, input logic stall,
                                         input logic taken, input pc_t target);
        logic pt;
        logic at;
        if (!ex.valid || stall) begin
            return FIX_NONE; // nothing resolves in a bubble or a stall
        end
        pt = ex.pred_taken;
        at = cls_q[ex.pc[5:0]] >= CLS_JAL && taken;
        case ({pt, at})
            2'b10:   return FIX_NOT_TAKEN;
            2'b01:   return FIX_TAKEN;
            2'b11:   return (ex.pred_target == target) ? FIX_NONE : FIX_TARGET;
            default: return FIX_NONE;
        endcase
    endfunction

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] got);
        if (exp !== got) begin
            $display("[ERROR] %s expected %h got %h", name, exp, got);
            $display("TB FAILED");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic fill_program();
        logic [1:0] mode;
        for (int s = 0; s < 64; s++) begin
            cls_q[s] = rand_bits(2);
            tgt_q[s] = rand_bits(6);
            if (tgt_q[s] == 6'(s)) begin
                tgt_q[s] = 6'(s) ^ 6'd8; // no jump onto itself
            end
            mode = rand_bits(2);
            case (mode)
                2'd0:    bias_q[s] = 8'hff; // always taken
                2'd1:    bias_q[s] = 8'h00;
                default: bias_q[s] = rand_bits(8);
            endcase
            iter_q[s] = 0;
        end
    endtask

    task automatic reset_model();
        for (int i = 0; i < ENTRIES; i++) begin
            btb_m[i] = BASE_PC;
            ctr_m[i] = '0;
        end
        ghr_m    = '0;
        fpc_m    = BASE_PC;
        fd_m     = '0;
        fd_m.pc  = BASE_PC;
        ex_m     = fd_m;
        resolved = 0;
        hits     = 0;
    endtask

    // all outputs against the model, stalled cycles included
    task automatic check_outputs();
        fix_kind_e kind;
        kind = fix_of(ex_m, stall_i, exec_taken_i, exec_target_i);
        check_eq("fetch_pc_o", fpc_m, fetch_pc_o);
        check_eq("exec_valid_o", ex_m.valid, exec_valid_o);
        if (ex_m.valid) begin
            check_eq("exec_pc_o", ex_m.pc, exec_pc_o);
        end
        check_eq("redirect_valid_o", kind != FIX_NONE, redirect_valid_o);
        if (kind != FIX_NONE) begin
            check_eq("redirect_kind_o", kind, redirect_kind_o);
        end
    endtask

    // model state update for one clock edge
    task automatic advance_model();
        logic [5:0] es;
        bp_index_t  lidx;
        bp_index_t  cidx;
        ghr_t       ghr_old;
        logic       lt;
        pc_t        ltgt;
        logic       at;
        pc_t        rpc;
        fix_kind_e  kind;
        es      = ex_m.pc[5:0];
        lidx    = fpc_m[`BP_INDEX_BITS-1:0];
        ghr_old = ghr_m;
        lt      = ctr_m[lidx ^ ghr_m][1];
        ltgt    = btb_m[lidx];
        kind    = fix_of(ex_m, stall_i, exec_taken_i, exec_target_i);
        if (stall_i) return;
        at  = ex_m.valid && cls_q[es] >= CLS_JAL && exec_taken_i;
        rpc = (kind == FIX_NOT_TAKEN) ? ex_m.pc + len_of(cls_q[es]) : exec_target_i;
        if (ex_m.valid) begin
            resolved++;
            if (at && kind == FIX_NONE) hits++;
            if (at && kind != FIX_NONE) btb_m[es[4:0]] = exec_target_i;
            if (cls_q[es] == CLS_BRANCH) begin
                cidx = es[4:0] ^ ex_m.ghr_snap; // history seen at fetch
                if (at && ctr_m[cidx] != 2'd3) begin
                    ctr_m[cidx] = ctr_m[cidx] + 2'd1;
                end else if (!at && ctr_m[cidx] != 2'd0) begin
                    ctr_m[cidx] = ctr_m[cidx] - 2'd1;
                end
                ghr_m = {ghr_m[`BP_HIST_BITS-2:0], at};
                iter_q[es]++;
            end
        end
        ex_m       = fd_m;
        ex_m.valid = fd_m.valid && kind == FIX_NONE;
        fd_m       = '{valid: kind == FIX_NONE, pc: fpc_m, pred_taken: lt,
                       pred_target: ltgt, ghr_snap: ghr_old};
        if (kind != FIX_NONE) fpc_m = rpc;
        else if (lt)          fpc_m = ltgt;
        else                  fpc_m = fpc_m + len_of(cls_q[fpc_m[5:0]]);
    endtask

    task automatic drive_inputs();
        logic [5:0] es;
        es = ex_m.pc[5:0];
        stall_i       <= rand_bits(3) == 3'd0; // about 1 in 8
        instr_i       <= instr_of(cls_q[fpc_m[5:0]]);
        exec_target_i <= BASE_PC + pc_t'(tgt_q[es]);
        case (cls_q[es])
            CLS_JAL:    exec_taken_i <= 1'b1;
            CLS_BRANCH: exec_taken_i <= bias_q[es][iter_q[es] % 8];
            default:    exec_taken_i <= rand_bits(1); // must be ignored
        endcase
    endtask

    initial begin
        rst_i         = 1'b1;
        stall_i       = 1'b0;
        instr_i       = 32'h0000_0013;
        exec_taken_i  = 1'b0;
        exec_target_i = '0;
        lfsr_q        = 32'hb52a;
        fill_program();
        reset_model();
        repeat (8) @(posedge clk_i);
        rst_i <= 1'b0;
        drive_inputs();
        for (int c = 0; c < N_CYCLES; c++) begin
            @(negedge clk_i);
            check_outputs();
            @(posedge clk_i);
            advance_model();
            drive_inputs();
        end
        $display("resolved %0d instructions, %0d taken predictions correct", resolved, hits);
        $display("TB PASSED");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("TB FAILED");
        $fatal(1, "watchdog");
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+rtl
rtl/bp_types_pkg.sv
rtl/pipe_pkg.sv
rtl/pc_gen.sv
rtl/gshare_predictor.sv
rtl/branch_decode.sv
rtl/branch_check.sv
rtl/branch_front_end.sv
verification/tb_branch_front_end.sv
